// ==== mduTop.f ====
source/mduPkg.sv
source/mduMultiplier.sv
source/mduDivider.sv
source/mduController.sv
source/mduTop.sv
testbench/mduTb.sv

// ==== Makefile ====
VERILATOR    ?= verilator
TOP          := mduTb
RTL_TOP      := mduTop
FILELIST     := mduTop.f
OBJ_DIR      := obj_dir
COMMON_FLAGS := --timing --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS   := --lint-only -Wall
SIM_FLAGS    := --binary -j 0
PASS_TEXT    := RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) \
		-f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/mduTb.sv ====
`default_nettype none

module mduTb import mduPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// Longest legal busy stretch plus slack
	localparam int BusyTimeout = DivLatency + 16;

	logic clk;
	logic arstN;
	mduRequestT request;
	logic start;
	logic clear;
	logic [31:0] hi;
	logic [31:0] lo;
	logic [31:0] readData;
	logic busy;

	integer seed;

	mduTop dut_i (
		.clk(clk),
		.arstN(arstN),
		.request(request),
		.start(start),
		.clear(clear),
		.hi(hi),
		.lo(lo),
		.readData(readData),
		.busy(busy)
	);

	// 100 ns period
	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Checking and reference model
	////////////////////////////////////////////////////////////////////////////

	task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("RESULT: FAIL");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	// Cycles of busy per engine
	function automatic int latencyOf(input mduOpE op);
		if (op == opMult || op == opMultu) begin
			return MulLatency;
		end
		return DivLatency;
	endfunction

	// HI:LO as the instruction set defines them
	task automatic modelResult(input mduOpE op, input logic [31:0] a, input logic [31:0] b,
			output logic [31:0] expHi, output logic [31:0] expLo);
		longint sa;
		longint sb;
		longint q;
		longint r;
		logic [63:0] prod;
		sa = $signed(a);
		sb = $signed(b);
		prod = '0;
		case (op)
			opMult: prod = sa * sb;
			opMultu: prod = {32'b0, a} * {32'b0, b};
			opDiv: begin
				// 64-bit math keeps most negative / -1 from overflowing
				if (b == '0) begin
					prod = {a, 32'hffff_ffff};
				end else begin
					q = sa / sb;
					r = sa % sb;
					prod = {r[31:0], q[31:0]};
				end
			end
			opDivu: begin
				if (b == '0) begin
					prod = {a, 32'hffff_ffff};
				end else begin
					prod = {a % b, a / b};
				end
			end
			default: prod = '0;
		endcase
		expHi = prod[63:32];
		expLo = prod[31:0];
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Drivers
	////////////////////////////////////////////////////////////////////////////

	// Returns just after the start edge
	task automatic startOp(input mduOpE op, input logic [31:0] a, input logic [31:0] b);
		@(posedge clk);
		request.op <= op;
		request.srcA <= a;
		request.srcB <= b;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		request.op <= opNone;
	endtask

	// Counts falling edges with busy high
	task automatic waitIdle(output int cycles);
		cycles = 0;
		@(negedge clk);
		while (busy && cycles <= BusyTimeout) begin
			cycles++;
			@(negedge clk);
		end
		if (busy) begin
			$display("Timeout: busy still high after %0d cycles", cycles);
			$display("RESULT: FAIL");
			$fatal(1, "Busy never dropped");
		end
	endtask

	task automatic runOp(input mduOpE op, input logic [31:0] a, input logic [31:0] b);
		int cycles;
		logic [31:0] expHi;
		logic [31:0] expLo;
		startOp(op, a, b);
		waitIdle(cycles);
		checkValue(cycles, latencyOf(op), $sformatf("%s busy cycles", op.name()));
		modelResult(op, a, b, expHi, expLo);
		checkValue({hi, lo}, {expHi, expLo}, $sformatf("%s %h, %h", op.name(), a, b));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic testResetAndMoves();
		@(negedge clk);
		checkValue(hi, 0, "hi after reset");
		checkValue(lo, 0, "lo after reset");
		checkValue(readData, 0, "readData after reset");
		checkValue(busy, 0, "busy after reset");
		@(posedge clk);
		request.op <= opMthi;
		request.srcA <= 32'hcafe_0001;
		@(posedge clk);
		request.op <= opMtlo;
		request.srcA <= 32'h0bad_f00d;
		@(posedge clk);
		request.op <= opMfhi;
		@(negedge clk);
		checkValue(readData, 32'hcafe_0001, "mfhi after mthi");
		@(posedge clk);
		request.op <= opMflo;
		@(negedge clk);
		checkValue(readData, 32'h0bad_f00d, "mflo after mtlo");
		@(posedge clk);
		request.op <= opNone;
		@(negedge clk);
		checkValue(readData, 0, "readData with no read op");
	endtask

	task automatic testMultiply();
		logic [31:0] corners [5];
		logic [31:0] a;
		logic [31:0] b;
		// Zero, one, minus one / max unsigned, most negative, max positive
		corners = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
		for (int i = 0; i < 5; i++) begin
			for (int j = 0; j < 5; j++) begin
				runOp(opMult, corners[i], corners[j]);
				runOp(opMultu, corners[i], corners[j]);
			end
		end
		repeat (20) begin
			a = $random(seed);
			b = $random(seed);
			runOp(opMult, a, b);
			runOp(opMultu, a, b);
		end
	endtask

	task automatic testDivide();
		logic [31:0] dividends [6];
		logic [31:0] divisors [6];
		logic [31:0] a;
		logic [31:0] b;
		dividends = '{-32'sd7, 32'd7, -32'sd7, 32'h8000_0000, 32'hffff_ffff, 32'd100};
		divisors = '{32'd2, -32'sd2, -32'sd2, 32'hffff_ffff, 32'd1, 32'd7};
		for (int i = 0; i < 6; i++) begin
			runOp(opDiv, dividends[i], divisors[i]);
			runOp(opDivu, dividends[i], divisors[i]);
		end
		repeat (20) begin
			a = $random(seed);
			b = $random(seed);
			runOp(opDiv, a, b);
			runOp(opDivu, a, b);
			// Small divisor gives wide quotients
			b = $random(seed) & 32'h0000_00ff;
			runOp(opDiv, a, b);
			runOp(opDivu, a, b);
		end
	endtask

	task automatic testDivideByZero();
		runOp(opDiv, 32'hdead_beef, 32'h0);
		checkValue(lo, 32'hffff_ffff, "div by zero quotient");
		checkValue(hi, 32'hdead_beef, "div by zero remainder");
		runOp(opDivu, 32'h1234_5678, 32'h0);
		checkValue(lo, 32'hffff_ffff, "divu by zero quotient");
		checkValue(hi, 32'h1234_5678, "divu by zero remainder");
	endtask

	// Abort op after delay cycles, then check a fresh multiply
	task automatic clearDuring(input mduOpE op, input int delay);
		@(posedge clk);
		request.op <= opMthi;
		request.srcA <= 32'h5555_aaaa;
		@(posedge clk);
		request.op <= opMtlo;
		request.srcA <= 32'haaaa_5555;
		startOp(op, 32'h8765_4321, 32'h0000_0123);
		repeat (delay) @(posedge clk);
		clear <= 1'b1;
		@(posedge clk);
		clear <= 1'b0;
		@(negedge clk);
		checkValue(busy, 0, $sformatf("busy after clear during %s", op.name()));
		checkValue({hi, lo}, 0, $sformatf("hi:lo after clear during %s", op.name()));
		runOp(opMult, 32'h0000_1234, 32'hffff_fff0);
		runOp(op, 32'h0000_7777, 32'h0000_0011);
	endtask

	task automatic testClear();
		clearDuring(opDiv, 10);
		// Aborted product still in the first stage
		clearDuring(opMultu, 0);
	endtask

	task automatic testBusyIgnores();
		int cycles;
		logic [31:0] expHi;
		logic [31:0] expLo;
		// Known HI ahead of the long divide
		@(posedge clk);
		request.op <= opMthi;
		request.srcA <= 32'h1357_2468;
		startOp(opDivu, 32'h8765_4321, 32'h0000_0123);
		// Second start lands while busy
		@(posedge clk);
		request.op <= opMultu;
		request.srcA <= 32'h0001_0003;
		request.srcB <= 32'h0002_0005;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		request.op <= opMthi;
		request.srcA <= 32'hffff_0000;
		@(posedge clk);
		request.op <= opMfhi;
		@(negedge clk);
		// Old HI still readable mid divide
		checkValue(readData, 32'h1357_2468, "mfhi while busy after mthi");
		waitIdle(cycles);
		modelResult(opDivu, 32'h8765_4321, 32'h0000_0123, expHi, expLo);
		checkValue({hi, lo}, {expHi, expLo}, "hi:lo after ignored start and mthi");
	endtask

	initial begin
		seed = 32'h0ad75202;
		clk = 1'b0;
		arstN = 1'b0;
		request = '0;
		start = 1'b0;
		clear = 1'b0;
		repeat (4) @(posedge clk);
		arstN <= 1'b1;
		testResetAndMoves();
		testMultiply();
		testDivide();
		testDivideByZero();
		testClear();
		testBusyIgnores();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/mduTop.sv ====
`default_nettype none

module mduTop import mduPkg::*; (
	input  logic        clk,
	input  logic        arstN,
	input  mduRequestT  request,
	input  logic        start,
	input  logic        clear,
	output logic [31:0] hi,
	output logic [31:0] lo,
	output logic [31:0] readData,
	output logic        busy
);

	// Controller to engines
	logic mulStart;
	logic divStart;
	logic opSigned;
	logic flush;

	// Engines to controller
	logic mulDone;
	logic divDone;
	mduResultT mulResult;
	mduResultT divResult;

	mduController ctrl_i (
		.clk(clk),
		.arstN(arstN),
		.request(request),
		.start(start),
		.clear(clear),
		.mulDone(mulDone),
		.mulResult(mulResult),
		.divDone(divDone),
		.divResult(divResult),
		.mulStart(mulStart),
		.divStart(divStart),
		.opSigned(opSigned),
		.flush(flush),
		.hi(hi),
		.lo(lo),
		.readData(readData),
		.busy(busy)
	);

	// Operands go straight from the request, sampled on the start edge
	mduMultiplier mul_i (
		.clk(clk),
		.arstN(arstN),
		.start(mulStart),
		.signedOp(opSigned),
		.flush(flush),
		.a(request.srcA),
		.b(request.srcB),
		.done(mulDone),
		.result(mulResult)
	);

	mduDivider div_i (
		.clk(clk),
		.arstN(arstN),
		.start(divStart),
		.signedOp(opSigned),
		.flush(flush),
		.dividend(request.srcA),
		.divisor(request.srcB),
		.done(divDone),
		.result(divResult)
	);

endmodule

`default_nettype wire

// ==== source/mduController.sv ====
`default_nettype none

module mduController import mduPkg::*; (
	input  logic        clk,
	input  logic        arstN,
	input  mduRequestT  request,
	input  logic        start,
	input  logic        clear,
	input  logic        mulDone,
	input  mduResultT   mulResult,
	input  logic        divDone,
	input  mduResultT   divResult,
	output logic        mulStart,
	output logic        divStart,
	output logic        opSigned,
	output logic        flush,
	output logic [31:0] hi,
	output logic [31:0] lo,
	output logic [31:0] readData,
	output logic        busy
);

	// Decoded request
	logic isMul;
	logic isDiv;
	logic accept;

	// Result from whichever engine finished
	mduResultT doneResult;
	logic engineDone;

	////////////////////////////////////////////////////////////////////////////
	// Decode and dispatch
	////////////////////////////////////////////////////////////////////////////

	assign isMul = (request.op == opMult) || (request.op == opMultu);
	assign isDiv = (request.op == opDiv) || (request.op == opDivu);

	// Start only counts when idle, clear wins
	assign accept = start && !busy && !clear;

	assign mulStart = accept && isMul;
	assign divStart = accept && isDiv;
	assign opSigned = (request.op == opMult) || (request.op == opDiv);

	// Engines abort on the same edge as HI/LO clear
	assign flush = clear;

	////////////////////////////////////////////////////////////////////////////
	// Completion
	////////////////////////////////////////////////////////////////////////////

	assign engineDone = mulDone || divDone;

	// Only one engine runs at a time
	assign doneResult = divDone ? divResult : mulResult;

	////////////////////////////////////////////////////////////////////////////
	// Busy and HI/LO
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			busy <= 1'b0;
			hi <= '0;
			lo <= '0;
		end else if (clear) begin
			busy <= 1'b0;
			hi <= '0;
			lo <= '0;
		end else if (busy) begin
			// Move-to and start ignored here
			if (engineDone) begin
				hi <= doneResult.hi;
				lo <= doneResult.lo;
				busy <= 1'b0;
			end
		end else if (mulStart || divStart) begin
			busy <= 1'b1;
		end else if (request.op == opMthi) begin
			hi <= request.srcA;
		end else if (request.op == opMtlo) begin
			lo <= request.srcA;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////////////////////

	// Registers as they stand, stale while busy
	always_comb begin
		case (request.op)
			opMfhi: readData = hi;
			opMflo: readData = lo;
			default: readData = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/mduDivider.sv ====
`default_nettype none

module mduDivider import mduPkg::*; (
	input  logic        clk,
	input  logic        arstN,
	input  logic        start,
	input  logic        signedOp,
	input  logic        flush,
	input  logic [31:0] dividend,
	input  logic [31:0] divisor,
	output logic        done,
	output mduResultT   result
);

	typedef enum logic [1:0] {
		divIdle,
		divLoad,
		divIterate,
		divFix
	} divStateE;

	typedef logic [$clog2(DivIterations)-1:0] iterCountT;

	divStateE state;
	iterCountT iterCount;

	// Raw operands held from the start edge
	logic [31:0] dividendReg;
	logic [31:0] divisorReg;
	logic signedReg;

	// Working registers
	logic [31:0] remainder;
	logic [31:0] quotient;
	logic [31:0] divisorMag;
	logic quotNeg;
	logic remNeg;
	logic zeroDivisor;

	// Load step helpers
	logic dividendNeg;
	logic divisorNeg;

	// One restoring step
	logic [32:0] shifted;
	logic [33:0] trial;

	assign dividendNeg = signedReg & dividendReg[31];
	assign divisorNeg = signedReg & divisorReg[31];

	// Bring next dividend bit into the partial remainder
	assign shifted = {remainder, quotient[31]};
	assign trial = {1'b0, shifted} - {2'b0, divisorMag};

	////////////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= divIdle;
			iterCount <= '0;
		end else if (flush) begin
			// Abort whatever is in flight
			state <= divIdle;
			iterCount <= '0;
		end else begin
			case (state)
				divIdle: begin
					if (start) begin
						state <= divLoad;
					end
				end
				divLoad: begin
					state <= divIterate;
					iterCount <= '0;
				end
				divIterate: begin
					iterCount <= iterCount + 1'b1;
					if (iterCount == iterCountT'(DivIterations - 1)) begin
						state <= divFix;
					end
				end
				default: begin
					// Result taken by the controller this cycle
					state <= divIdle;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (state == divIdle && start) begin
			dividendReg <= dividend;
			divisorReg <= divisor;
			signedReg <= signedOp;
		end

		if (state == divLoad) begin
			// Quotient register starts out holding the dividend magnitude
			remainder <= '0;
			quotient <= dividendNeg ? -dividendReg : dividendReg;
			divisorMag <= divisorNeg ? -divisorReg : divisorReg;
			quotNeg <= dividendNeg ^ divisorNeg;
			// Remainder takes the dividend sign
			remNeg <= dividendNeg;
			zeroDivisor <= (divisorReg == '0);
		end

		if (state == divIterate) begin
			if (!trial[33]) begin
				// Fits, keep the difference
				remainder <= trial[31:0];
				quotient <= {quotient[30:0], 1'b1};
			end else begin
				// Restore
				remainder <= shifted[31:0];
				quotient <= {quotient[30:0], 1'b0};
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sign fix and output
	////////////////////////////////////////////////////////////////////////////

	assign done = (state == divFix);

	always_comb begin
		if (zeroDivisor) begin
			// Defined result for x / 0
			result.hi = dividendReg;
			result.lo = '1;
		end else begin
			result.hi = remNeg ? -remainder : remainder;
			result.lo = quotNeg ? -quotient : quotient;
		end
	end

endmodule

`default_nettype wire

// ==== source/mduMultiplier.sv ====
`default_nettype none

module mduMultiplier import mduPkg::*; (
	input  logic        clk,
	input  logic        arstN,
	input  logic        start,
	input  logic        signedOp,
	input  logic        flush,
	input  logic [31:0] a,
	input  logic [31:0] b,
	output logic        done,
	output mduResultT   result
);

	// Operand signs, only meaningful for mult
	logic aNeg;
	logic bNeg;
	logic [31:0] aMag;
	logic [31:0] bMag;

	// Stage 1, magnitudes
	logic [31:0] aMag1;
	logic [31:0] bMag1;
	logic neg1;

	// Stage 2, partial products
	logic [31:0] pLow2;
	logic [31:0] pHigh2;
	logic [32:0] pMid2;
	logic neg2;

	// Stage 3, unsigned product
	logic [63:0] mag3;
	logic neg3;

	// Stage 4, final product
	logic [63:0] product4;

	// One valid bit per stage
	logic [MulLatency-1:0] valid;

	assign aNeg = signedOp & a[31];
	assign bNeg = signedOp & b[31];
	// Most negative word maps onto itself, still correct as unsigned
	assign aMag = aNeg ? -a : a;
	assign bMag = bNeg ? -b : b;

	////////////////////////////////////////////////////////////////////////////
	// Valid chain
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			valid <= '0;
		end else if (flush) begin
			valid <= '0;
		end else begin
			valid <= {valid[MulLatency-2:0], start};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		// Capture magnitudes and result sign
		aMag1 <= aMag;
		bMag1 <= bMag;
		neg1 <= aNeg ^ bNeg;

		// Four 16x16 products, cross terms summed here
		pLow2 <= aMag1[15:0] * bMag1[15:0];
		pHigh2 <= aMag1[31:16] * bMag1[31:16];
		pMid2 <= aMag1[15:0] * bMag1[31:16] + aMag1[31:16] * bMag1[15:0];
		neg2 <= neg1;

		// Middle term lands 16 bits up
		mag3 <= {pHigh2, pLow2} + {15'b0, pMid2, 16'b0};
		neg3 <= neg2;

		// Back to two's complement
		product4 <= neg3 ? -mag3 : mag3;
	end

	assign done = valid[MulLatency-1];
	assign result.hi = product4[63:32];
	assign result.lo = product4[31:0];

endmodule

`default_nettype wire

// ==== source/mduPkg.sv ====
`default_nettype none

package mduPkg;

	////////////////////////////////////////////////////////////////////////////
	// Operations
	////////////////////////////////////////////////////////////////////////////

	// MDU operation codes as decoded by the processor
	typedef enum logic [3:0] {
		opNone,
		opMfhi,
		opMflo,
		opMthi,
		opMtlo,
		opMult,
		opMultu,
		opDiv,
		opDivu
	} mduOpE;

	////////////////////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////////////////////

	// Operands presented with each request
	typedef struct packed {
		mduOpE       op;
		logic [31:0] srcA;
		logic [31:0] srcB;
	} mduRequestT;

	// Engine result, HI in the upper word
	typedef struct packed {
		logic [31:0] hi;
		logic [31:0] lo;
	} mduResultT;

	////////////////////////////////////////////////////////////////////////////
	// Latencies
	////////////////////////////////////////////////////////////////////////////

	// Multiplier pipeline depth
	localparam int MulLatency = 4;
	// Restoring steps, one quotient bit each
	localparam int DivIterations = 32;
	// Load, iterations, sign fix
	localparam int DivLatency = DivIterations + 2;

endpackage

`default_nettype wire
